//--- ifmap_feed_tests.txt
# S layer_type col_en row_en dw_open_start_num dw_first_f (decimal)
# L ifmap_word dw_first_if_strobe   H ifmap_word held through the next drain
# C w0 w1 w2 w3 psum_col0 .. psum_col7 (hex)
# 1 compute straight after reset gives zero sums
C 01 02 03 04 00000 00000 00000 00000 00000 00000 00000 00000
# 2 standard steering with col_en 7, ninth load wraps to column 0
S 0 7 0 0 0
L 04030201 0
L 08070605 0
L 0c0b0a09 0
L 100f0e0d 0
L 14131211 0
L 18171615 0
L 1c1b1a19 0
L 201f1e1d 0
L ffffffff 0
C 01 02 03 04 009f6 00046 0006e 00096 000be 000e6 0010e 00136
# 3 reserved type clears the counter, then col_en 3
S 2 0 0 0 0
S 0 3 0 0 0
L 00000001 0
L 00000100 0
L ffffffff 0
L 01010101 0
L 000000ff 0
L 0000ff00 0
C 01 ff 10 02 000ff 0fe01 110ee 00112 00000 00000 00000 00000
# 4 depthwise first pass, row_en 2 and start 4 give columns 0 1 2 1 2
S 2 0 0 0 0
S 1 7 2 4 1
L 01020304 0
L 11111111 0
L 22222222 0
L 33333333 0
L 40302010 0
L 05050505 1
C 04 03 02 01 0001e 00032 00140 00000 00000 00000 00000 00000
# 4b depthwise with dw_first_f low, strobe pulls the counter back to 1
S 1 7 2 4 0
L 0a0b0c0d 0
L 00000080 0
L 000000ff 1
C 02 00 00 01 00000 001fe 00024 00100 00000 00000 00000 00000
# 5 word held with valid_if through a drain lands in the next column
S 0 7 0 0 0
L 11223344 0
H ffffffff
C ff ff ff ff 00000 00000 0a956 00000 00000 00000 00000 00000
C ff ff ff ff 00000 00000 00000 3f804 00000 00000 00000 00000

//--- filelist.f
accel_cfg_pkg.sv
layer_ctrl_pkg.sv
vertical_buffer.sv
ifmap_drain_ctrl.sv
pe_row.sv
ifmap_feed_top.sv
tb_ifmap_feed.sv

//--- Bender.yml
package:
  name: ifmap_feed

sources:
  - files:
      - accel_cfg_pkg.sv
      - layer_ctrl_pkg.sv
      - vertical_buffer.sv
      - ifmap_drain_ctrl.sv
      - pe_row.sv
      - ifmap_feed_top.sv
  - target: test
    files:
      - tb_ifmap_feed.sv

//--- tb_ifmap_feed.sv
`default_nettype none

module tb_ifmap_feed;

    timeunit 1ns;
    timeprecision 1ps;

    import accel_cfg_pkg::*;
    import layer_ctrl_pkg::*;

    logic                      clk;
    logic                      reset;
    logic [cnt_w-1:0]          col_en;
    logic [cnt_w-1:0]          row_en;
    logic [cnt_w-1:0]          dw_open_start_num;
    logic                      dw_first_f;
    logic                      dw_first_if;
    layer_type_t               pass_layer_type;
    logic                      valid_if;
    logic [word_w-1:0]         ifmap_in;
    logic                      ready_if;
    logic                      compute_start;
    logic [byte_w-1:0]         weight_in;
    logic [col_num*byte_w-1:0] ifmap_out;
    logic [col_num*acc_w-1:0]  psum_out;
    logic                      psum_valid;

    // reference model of the column counter and the FIFO contents
    logic [byte_w-1:0] model_fifo [col_num][fifo_depth];
    logic [cnt_w-1:0]  model_cnt;
    int                m_type;
    logic [cnt_w-1:0]  m_col_en;
    logic [cnt_w-1:0]  m_row_en;
    logic [cnt_w-1:0]  m_start;
    logic              m_first_f;

    logic [byte_w-1:0] weights [fifo_depth];
    logic [acc_w-1:0]  exp_psum [col_num];

    integer seed;
    int     errors;
    int     checks;
    int     wait_limit = 50;   // cycles allowed for any single wait

    ifmap_feed_top DUT (
        .clk               (clk),
        .reset             (reset),
        .col_en            (col_en),
        .row_en            (row_en),
        .dw_open_start_num (dw_open_start_num),
        .dw_first_f        (dw_first_f),
        .dw_first_if       (dw_first_if),
        .pass_layer_type   (pass_layer_type),
        .valid_if          (valid_if),
        .ifmap_in          (ifmap_in),
        .ready_if          (ready_if),
        .compute_start     (compute_start),
        .weight_in         (weight_in),
        .ifmap_out         (ifmap_out),
        .psum_out          (psum_out),
        .psum_valid        (psum_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_and_finish;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("gave up waiting for %s after %0d cycles", what, wait_limit);
        errors++;
        report_and_finish;
    endtask

    task automatic expect_equal(input string name, input int idx,
                                input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR %s col %0d got 0x%h exp 0x%h", name, idx, got, exp);
        end
    endtask

    // counter rule per layer type
    function automatic logic [cnt_w-1:0] next_col(input logic [cnt_w-1:0] c);
        logic [cnt_w-1:0] std_next;
        std_next = (c == m_col_en) ? '0 : c + 1'b1;
        case (m_type)
            0: return std_next;
            1: begin
                if (!m_first_f)
                    return std_next;
                return (c == m_row_en) ? m_start - 5'd3 : c + 1'b1;
            end
            default: return '0;
        endcase
    endfunction

    task automatic model_load(input logic [word_w-1:0] word, output logic [cnt_w-1:0] col);
        col = model_cnt;
        for (int k = 0; k < fifo_depth; k++)
            model_fifo[col][k] = word[k*byte_w +: byte_w];
        model_cnt = next_col(model_cnt);
    endtask

    task automatic apply_settings(input int t, input int ce, input int re,
                                  input int st, input int ff);
        @(posedge clk);
        pass_layer_type   <= layer_type_t'(t[1:0]);
        col_en            <= ce[cnt_w-1:0];
        row_en            <= re[cnt_w-1:0];
        dw_open_start_num <= st[cnt_w-1:0];
        dw_first_f        <= ff[0];
        m_type    = t;
        m_col_en  = ce[cnt_w-1:0];
        m_row_en  = re[cnt_w-1:0];
        m_start   = st[cnt_w-1:0];
        m_first_f = ff[0];
        if (t > 1)
            model_cnt = '0;   // reserved type parks the counter
    endtask

    task automatic load_word(input logic [word_w-1:0] word, input logic strobe);
        int               idle;
        int               n;
        logic [cnt_w-1:0] col;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge clk);
        @(posedge clk);
        if (strobe) begin
            dw_first_if <= 1'b1;
            @(posedge clk);   // idle cycle with the strobe
            dw_first_if <= 1'b0;
            if (m_type == 1)
                model_cnt = m_start - 5'd3;
        end
        valid_if <= 1'b1;
        ifmap_in <= word;
        n = 0;
        @(negedge clk);
        while (!ready_if) begin
            if (n == wait_limit)
                abort_on_timeout("ready_if on a load");
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        valid_if <= 1'b0;
        model_load(word, col);
        @(negedge clk);
        expect_equal("ifmap_out", col, ifmap_out[col*byte_w +: byte_w], word[byte_w-1:0]);
    endtask

    task automatic run_compute(input logic has_held, input logic [word_w-1:0] held);
        int               n;
        logic [acc_w-1:0] model_sum;
        logic [cnt_w-1:0] col;
        @(posedge clk);
        compute_start <= 1'b1;
        @(posedge clk);   // pulse is sampled here
        compute_start <= 1'b0;
        weight_in     <= weights[0];
        if (has_held) begin
            valid_if <= 1'b1;
            ifmap_in <= held;
        end
        for (int k = 0; k < fifo_depth; k++) begin
            @(negedge clk);
            expect_equal("ready_if in drain", k, ready_if, 0);
            expect_equal("psum_valid in drain", k, psum_valid, 0);
            @(posedge clk);
            if (k < fifo_depth - 1)
                weight_in <= weights[k+1];
        end
        n = 0;
        @(negedge clk);
        while (!psum_valid) begin
            if (n == wait_limit)
                abort_on_timeout("psum_valid");
            n++;
            @(negedge clk);
        end
        checks++;
        assert (n == 0) else begin
            errors++;
            $display("psum_valid came %0d cycles after compute_start instead of 5", n + 5);
        end
        for (int c = 0; c < col_num; c++) begin
            model_sum = '0;
            for (int k = 0; k < fifo_depth; k++)
                model_sum = model_sum + acc_w'(model_fifo[c][k]) * acc_w'(weights[k]);
            expect_equal("expected psum vs model", c, exp_psum[c], model_sum);
            expect_equal("psum_out", c, psum_out[c*acc_w +: acc_w], exp_psum[c]);
            for (int k = 0; k < fifo_depth; k++)
                model_fifo[c][k] = '0;   // drained, zero filled
        end
        if (has_held) begin
            expect_equal("ready_if after drain", 0, ready_if, 1);
            @(posedge clk);   // held word goes in on this edge
            valid_if <= 1'b0;
            model_load(held, col);
        end
        @(negedge clk);
        expect_equal("psum_valid after pulse", 0, psum_valid, 0);  // single cycle pulse
        if (has_held)
            expect_equal("ifmap_out", col, ifmap_out[col*byte_w +: byte_w], held[byte_w-1:0]);
    endtask

    initial begin
        int                fd;
        int                code;
        int                s_type;
        int                s_col;
        int                s_row;
        int                s_start;
        int                s_first;
        int                strobe;
        logic [8*8-1:0]    tok;
        logic [8*120-1:0]  line;
        logic [word_w-1:0] word;
        logic [word_w-1:0] held_word;
        logic              held;
        logic              done;
        seed   = 32'h6fe7_4c9b;
        errors = 0;
        checks = 0;
        held   = 1'b0;
        done   = 1'b0;
        reset             = 1'b1;
        col_en            = '0;
        row_en            = '0;
        dw_open_start_num = '0;
        dw_first_f        = 1'b0;
        dw_first_if       = 1'b0;
        pass_layer_type   = layer_std;
        valid_if          = 1'b0;
        ifmap_in          = '0;
        compute_start     = 1'b0;
        weight_in         = '0;
        model_cnt = '0;
        m_type    = 0;
        m_col_en  = '0;
        m_row_en  = '0;
        m_start   = '0;
        m_first_f = 1'b0;
        for (int c = 0; c < col_num; c++)
            for (int k = 0; k < fifo_depth; k++)
                model_fifo[c][k] = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_equal("ready_if after reset", 0, ready_if, 1);
        expect_equal("psum_valid after reset", 0, psum_valid, 0);
        for (int c = 0; c < col_num; c++) begin
            expect_equal("psum_out after reset", c, psum_out[c*acc_w +: acc_w], 0);
            expect_equal("ifmap_out after reset", c, ifmap_out[c*byte_w +: byte_w], 0);
        end

        fd = $fopen("ifmap_feed_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            errors++;
        end else begin
            while (!done) begin
                code = $fscanf(fd, " %s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok == "#") begin
                    code = $fgets(line, fd);
                end else if (tok == "S") begin
                    code = $fscanf(fd, " %d %d %d %d %d",
                                   s_type, s_col, s_row, s_start, s_first);
                    apply_settings(s_type, s_col, s_row, s_start, s_first);
                end else if (tok == "L") begin
                    code = $fscanf(fd, " %h %d", word, strobe);
                    load_word(word, strobe[0]);
                end else if (tok == "H") begin
                    code = $fscanf(fd, " %h", held_word);
                    held = 1'b1;
                end else if (tok == "C") begin
                    for (int k = 0; k < fifo_depth; k++)
                        code = $fscanf(fd, " %h", weights[k]);
                    for (int c = 0; c < col_num; c++)
                        code = $fscanf(fd, " %h", exp_psum[c]);
                    run_compute(held, held_word);
                    held = 1'b0;
                end else begin
                    $display("unknown record kind in the test vector file");
                    errors++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
        repeat (2) @(posedge clk);
        report_and_finish;
    end

endmodule

`default_nettype wire

//--- ifmap_feed_top.sv
`default_nettype none

module ifmap_feed_top (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                        col_en,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                        row_en,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                        dw_open_start_num,
    input  logic                                                    dw_first_f,
    input  logic                                                    dw_first_if,
    input  layer_ctrl_pkg::layer_type_t                             pass_layer_type,
    input  logic                                                    valid_if,
    input  logic [accel_cfg_pkg::word_w-1:0]                        ifmap_in,
    output logic                                                    ready_if,
    input  logic                                                    compute_start,
    input  logic [accel_cfg_pkg::byte_w-1:0]                        weight_in,
    output logic [accel_cfg_pkg::col_num*accel_cfg_pkg::byte_w-1:0] ifmap_out,
    output logic [accel_cfg_pkg::col_num*accel_cfg_pkg::acc_w-1:0]  psum_out,
    output logic                                                    psum_valid
);

    logic shift_en;
    logic drain_first;
    logic drain_last;

    ifmap_drain_ctrl u_drain_ctrl (
        .clk           (clk),
        .reset         (reset),
        .compute_start (compute_start),
        .shift_en      (shift_en),
        .drain_busy    (),           // ready_if already reflects it
        .ready_if      (ready_if),
        .drain_first   (drain_first),
        .drain_last    (drain_last)
    );

    vertical_buffer u_vbuf (
        .clk               (clk),
        .reset             (reset),
        .col_en            (col_en),
        .row_en            (row_en),
        .dw_open_start_num (dw_open_start_num),
        .dw_first_f        (dw_first_f),
        .dw_first_if       (dw_first_if),
        .pass_layer_type   (pass_layer_type),
        .valid_if          (valid_if),
        .ready_if          (ready_if),
        .ifmap_in          (ifmap_in),
        .shift_en          (shift_en),
        .ifmap_out         (ifmap_out)
    );

    pe_row u_pe_row (
        .clk         (clk),
        .reset       (reset),
        .shift_en    (shift_en),
        .drain_first (drain_first),
        .drain_last  (drain_last),
        .ifmap_out   (ifmap_out),
        .weight_in   (weight_in),
        .psum_out    (psum_out),
        .psum_valid  (psum_valid)
    );

endmodule

`default_nettype wire

//--- pe_row.sv
`default_nettype none

module pe_row (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   shift_en,
    input  logic                                                   drain_first,
    input  logic                                                   drain_last,
    input  logic [accel_cfg_pkg::col_num*accel_cfg_pkg::byte_w-1:0] ifmap_out,
    input  logic [accel_cfg_pkg::byte_w-1:0]                       weight_in,
    output logic [accel_cfg_pkg::col_num*accel_cfg_pkg::acc_w-1:0]  psum_out,
    output logic                                                   psum_valid
);

    import accel_cfg_pkg::*;

    for (genvar c = 0; c < col_num; c++) begin : g_pe
        logic [byte_w-1:0] pixel;
        logic [prod_w-1:0] prod;
        logic [acc_w-1:0]  prod_ext;
        logic [acc_w-1:0]  acc;      // running sum inside a drain
        logic [acc_w-1:0]  psum_q;   // finished sum, held between drains

        assign pixel    = ifmap_out[c*byte_w +: byte_w];
        assign prod     = pixel * weight_in;  // unsigned 8x8
        assign prod_ext = {{(acc_w - prod_w){1'b0}}, prod};

        always_ff @(posedge clk) begin
            if (shift_en) begin
                if (drain_first)
                    acc <= prod_ext;  // fresh sum each drain
                else
                    acc <= acc + prod_ext;
            end
        end

        // last product goes straight into the output register
        always_ff @(posedge clk) begin
            if (reset)
                psum_q <= '0;
            else if (shift_en && drain_last)
                psum_q <= acc + prod_ext;
        end

        assign psum_out[c*acc_w +: acc_w] = psum_q;
    end

    always_ff @(posedge clk) begin
        if (reset)
            psum_valid <= 1'b0;
        else
            psum_valid <= shift_en && drain_last;  // one cycle after the last product
    end

    // frame markers come from the drain controller and must sit inside a shift
    a_marks_inside_shift: assert property (
        @(posedge clk) disable iff (reset) (drain_first || drain_last) |-> shift_en
    ) else $error("drain_first or drain_last without shift_en");

endmodule

`default_nettype wire

//--- ifmap_drain_ctrl.sv
`default_nettype none

module ifmap_drain_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic compute_start,
    output logic shift_en,
    output logic drain_busy,
    output logic ready_if,
    output logic drain_first,
    output logic drain_last
);

    import accel_cfg_pkg::*;

    // cycles left in the current drain, zero when idle
    logic [drain_cnt_w-1:0] drain_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            drain_cnt <= '0;
        end else if (compute_start && (drain_cnt == '0)) begin
            drain_cnt <= drain_cnt_w'(fifo_depth);  // one shift per FIFO entry
        end else if (drain_cnt != '0) begin
            drain_cnt <= drain_cnt - drain_cnt_w'(1);
        end
    end

    assign shift_en   = (drain_cnt != '0);
    assign drain_busy = shift_en;

    // first and last drain cycles frame the PE accumulation
    assign drain_first = (drain_cnt == drain_cnt_w'(fifo_depth));
    assign drain_last  = (drain_cnt == drain_cnt_w'(1));

    // no new words while the columns are emptying
    assign ready_if = !drain_busy;

    a_start_when_idle: assert property (
        @(posedge clk) disable iff (reset) compute_start |-> !drain_busy
    ) else $error("compute_start during an active drain");

endmodule

`default_nettype wire

//--- vertical_buffer.sv
`default_nettype none

module vertical_buffer (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                 col_en,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                 row_en,
    input  logic [layer_ctrl_pkg::cnt_w-1:0]                 dw_open_start_num,
    input  logic                                             dw_first_f,
    input  logic                                             dw_first_if,
    input  layer_ctrl_pkg::layer_type_t                      pass_layer_type,
    input  logic                                             valid_if,
    input  logic                                             ready_if,
    input  logic [accel_cfg_pkg::word_w-1:0]                 ifmap_in,
    input  logic                                             shift_en,
    output logic [accel_cfg_pkg::col_num*accel_cfg_pkg::byte_w-1:0] ifmap_out
);

    import accel_cfg_pkg::*;
    import layer_ctrl_pkg::*;

    // entry 0 is the output end of each column FIFO
    logic [byte_w-1:0] fifo [col_num][fifo_depth];

    logic [cnt_w-1:0] cnt;
    logic [cnt_w-1:0] cnt_next;
    logic [cnt_w-1:0] cnt_inc;
    logic [cnt_w-1:0] cnt_col_wrap;   // std style wrap at col_en
    logic [cnt_w-1:0] cnt_dw_wrap;    // depthwise first pass wrap at row_en
    logic [cnt_w-1:0] dw_restart;
    logic             transfer;

    assign transfer = valid_if && ready_if;

    assign cnt_inc      = cnt + cnt_w'(1);
    assign dw_restart   = dw_open_start_num - dw_restart_offset;
    assign cnt_col_wrap = (cnt == col_en) ? '0 : cnt_inc;
    assign cnt_dw_wrap  = (cnt == row_en) ? dw_restart : cnt_inc;

    always_comb begin
        cnt_next = cnt;
        case (pass_layer_type)
            layer_std: begin
                if (transfer)
                    cnt_next = cnt_col_wrap;
            end
            layer_dw: begin
                if (transfer)
                    cnt_next = dw_first_f ? cnt_dw_wrap : cnt_col_wrap;
                else if (dw_first_if)
                    cnt_next = dw_restart;  // idle strobe reloads the start point
            end
            default: begin
                cnt_next = '0;  // reserved types park the counter
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            cnt <= '0;
        else
            cnt <= cnt_next;
    end

    for (genvar c = 0; c < col_num; c++) begin : g_col
        always_ff @(posedge clk) begin
            if (reset) begin
                for (int k = 0; k < fifo_depth; k++)
                    fifo[c][k] <= '0;
            end else if (transfer && (cnt == cnt_w'(c))) begin
                // parallel load, byte 0 of the word lands at the output end
                for (int k = 0; k < fifo_depth; k++)
                    fifo[c][k] <= ifmap_in[k*byte_w +: byte_w];
            end else if (shift_en) begin
                for (int k = 0; k < fifo_depth - 1; k++)
                    fifo[c][k] <= fifo[c][k+1];
                fifo[c][fifo_depth-1] <= '0;   // zero fill behind the data
            end
        end

        assign ifmap_out[c*byte_w +: byte_w] = fifo[c][0];
    end

    // drain controller must hold off input while the FIFOs shift
    a_no_load_during_shift: assert property (
        @(posedge clk) disable iff (reset) transfer |-> !shift_en
    ) else $error("transfer while shift_en is high");

    a_layer_type_legal: assert property (
        @(posedge clk) disable iff (reset)
        transfer |-> (pass_layer_type inside {layer_std, layer_dw})
    ) else $error("transfer with reserved pass_layer_type %0d", pass_layer_type);

    // col_en, row_en and the dw restart point must all fit the array
    a_cnt_in_range: assert property (
        @(posedge clk) disable iff (reset) transfer |-> (cnt < col_num)
    ) else $error("column counter %0d outside array", cnt);

endmodule

`default_nettype wire

//--- layer_ctrl_pkg.sv
`default_nettype none

package layer_ctrl_pkg;

    // column counter width, 5 bits covers arrays up to 32 columns
    localparam int cnt_w = 5;

    // pass layer type, values 2 and 3 are reserved
    typedef enum logic [1:0] {
        layer_std = 2'd0,   // standard convolution
        layer_dw  = 2'd1    // depthwise convolution
    } layer_type_t;

    // depthwise restart point sits this far before dw_open_start_num
    localparam logic [cnt_w-1:0] dw_restart_offset = 5'd3;

endpackage

`default_nettype wire

//--- accel_cfg_pkg.sv
`default_nettype none

package accel_cfg_pkg;

    // array geometry
    localparam int col_num = 8;     // columns, one FIFO and one PE each
    localparam int fifo_depth = 4;  // entries per column FIFO, also bytes per input word

    // datapath widths
    localparam int byte_w = 8;                   // one ifmap element or one weight
    localparam int word_w = fifo_depth * byte_w; // ifmap_in carries a full column load
    localparam int prod_w = 2 * byte_w;          // unsigned byte by byte product

    // four unsigned 8x8 products need 18 bits
    localparam int acc_w = 18;

    // drain down-counter has to hold fifo_depth itself
    localparam int drain_cnt_w = $clog2(fifo_depth + 1);

endpackage

`default_nettype wire
